//--- app_cmd_if.sv
// One controller command request; addr and cmd must stay stable while en is high
`timescale 1ns/1ns

interface app_cmd_if #(
  parameter int adr_width = 27
) ();

  logic [adr_width-1:0] addr;
  logic [2:0] cmd;
  logic en;
  logic rdy;

  // Requesting controller side
  modport ctl (
    output addr,
    output cmd,
    output en,
    input  rdy
  );

  // Command mux side
  modport mux (
    input  addr,
    input  cmd,
    input  en,
    output rdy
  );

endinterface

//--- fml_ddr3_app_mux.sv
// Command port mux; read wins, and the two requesters are never expected to be active together
`timescale 1ns/1ns

module fml_ddr3_app_mux #(
  parameter int adr_width = 27
) (
  app_cmd_if.mux rd,
  app_cmd_if.mux wr,
  input  logic app_rdy,
  output logic [adr_width-1:0] app_addr,
  output logic [2:0] app_cmd,
  output logic app_en
);

  logic rd_sel;
  logic wr_sel;

  assign rd_sel = rd.en;
  assign wr_sel = wr.en & ~rd.en;

  // --------------------------------------------------
  // Request select
  // --------------------------------------------------
  // Idle port shows zero fields
  always_comb begin
    app_addr = '0;
    app_cmd = '0;
    if (rd_sel) begin
      app_addr = rd.addr;
      app_cmd = rd.cmd;
    end else if (wr_sel) begin
      app_addr = wr.addr;
      app_cmd = wr.cmd;
    end
  end

  assign app_en = rd_sel | wr_sel;

  // Ready only reaches the selected requester
  assign rd.rdy = app_rdy & rd_sel;
  assign wr.rdy = app_rdy & wr_sel;

endmodule

//--- fml_ddr3_bridge.sv
// FML to DDR3 app port bridge; single clock, one transaction in flight, no ECC or refresh control
`timescale 1ns/1ns

module fml_ddr3_bridge #(
  parameter int adr_width = 27,
  parameter int rd_delay = 5,
  parameter int wr_delay = 2
) (
  input  logic ui_clk,
  input  logic ui_rst,
  input  logic [adr_width-1:0] fml_adr,
  input  logic fml_stb,
  input  logic fml_we,
  input  logic [7:0] fml_sel,
  input  logic [fml_ddr3_pkg::qword_bits-1:0] fml_di,
  output logic fml_ack,
  output logic [fml_ddr3_pkg::qword_bits-1:0] fml_do,
  input  logic app_rdy,
  input  logic [fml_ddr3_pkg::app_data_bits-1:0] app_rd_data,
  input  logic app_rd_data_valid,
  input  logic app_rd_data_end,
  input  logic app_wdf_rdy,
  output logic [adr_width-1:0] app_addr,
  output logic [2:0] app_cmd,
  output logic app_en,
  output logic [fml_ddr3_pkg::app_data_bits-1:0] app_wdf_data,
  output logic [fml_ddr3_pkg::app_mask_bits-1:0] app_wdf_mask,
  output logic app_wdf_wren,
  output logic app_wdf_end
);

  logic rd_start;
  logic wr_start;
  logic rd_done;
  logic wr_done;
  logic [adr_width-1:0] burst_addr;
  fml_ddr3_pkg::app_word_u wr_word;
  fml_ddr3_pkg::app_mask_u wr_mask;
  fml_ddr3_pkg::app_word_u rd_word;

  app_cmd_if #(.adr_width(adr_width)) rd_cmd ();
  app_cmd_if #(.adr_width(adr_width)) wr_cmd ();

  // --------------------------------------------------
  // FML side
  // --------------------------------------------------
  fml_ddr3_front #(
    .adr_width(adr_width),
    .rd_delay(rd_delay),
    .wr_delay(wr_delay)
  ) u_front (
    .ui_clk(ui_clk), .ui_rst(ui_rst),
    .fml_adr(fml_adr), .fml_stb(fml_stb), .fml_we(fml_we),
    .fml_sel(fml_sel), .fml_di(fml_di), .fml_ack(fml_ack), .fml_do(fml_do),
    .rd_start(rd_start), .wr_start(wr_start), .burst_addr(burst_addr),
    .wr_word(wr_word), .wr_mask(wr_mask),
    .rd_done(rd_done), .wr_done(wr_done), .rd_word(rd_word)
  );

  // --------------------------------------------------
  // Controller side
  // --------------------------------------------------
  fml_ddr3_rd_ctl #(.adr_width(adr_width)) u_rd_ctl (
    .ui_clk(ui_clk), .ui_rst(ui_rst),
    .rd_start(rd_start), .burst_addr(burst_addr), .cmd(rd_cmd.ctl),
    .app_rd_data(app_rd_data), .app_rd_data_valid(app_rd_data_valid),
    .app_rd_data_end(app_rd_data_end), .rd_done(rd_done), .rd_word(rd_word)
  );

  fml_ddr3_wr_ctl #(.adr_width(adr_width)) u_wr_ctl (
    .ui_clk(ui_clk), .ui_rst(ui_rst),
    .wr_start(wr_start), .burst_addr(burst_addr),
    .wr_word(wr_word), .wr_mask(wr_mask), .cmd(wr_cmd.ctl),
    .app_wdf_rdy(app_wdf_rdy), .app_wdf_data(app_wdf_data),
    .app_wdf_mask(app_wdf_mask), .app_wdf_wren(app_wdf_wren),
    .app_wdf_end(app_wdf_end), .wr_done(wr_done)
  );

  fml_ddr3_app_mux #(.adr_width(adr_width)) u_app_mux (
    .rd(rd_cmd.mux), .wr(wr_cmd.mux), .app_rdy(app_rdy),
    .app_addr(app_addr), .app_cmd(app_cmd), .app_en(app_en)
  );

endmodule

//--- fml_ddr3_checker.sv
// Bus protocol assertions for the bridge; attached by bind, sets assert_fail on any violation
`timescale 1ns/1ns

module fml_ddr3_checker #(
  parameter int adr_width = 27
) (
  input logic ui_clk,
  input logic ui_rst,
  input logic fml_ack,
  input logic app_en,
  input logic app_rdy,
  input logic [adr_width-1:0] app_addr,
  input logic [2:0] app_cmd,
  input logic app_wdf_wren,
  input logic app_wdf_rdy,
  input logic app_wdf_end,
  input logic [fml_ddr3_pkg::app_data_bits-1:0] app_wdf_data
);

  logic assert_fail = 1'b0;

  // --------------------------------------------------
  // Command port and write data port rules
  // --------------------------------------------------
  a_cmd_hold: assert property (@(posedge ui_clk) disable iff (ui_rst)
    app_en && !app_rdy |=> app_en && $stable(app_addr) && $stable(app_cmd))
    else begin
      $error("app_en or its fields changed before app_rdy");
      assert_fail = 1'b1;
    end

  a_ack_pulse: assert property (@(posedge ui_clk) disable iff (ui_rst)
    fml_ack |=> !fml_ack)
    else begin
      $error("fml_ack stayed high for more than one cycle");
      assert_fail = 1'b1;
    end

  a_wren_hold: assert property (@(posedge ui_clk) disable iff (ui_rst)
    app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(app_wdf_data))
    else begin
      $error("app_wdf_wren or write data dropped before app_wdf_rdy");
      assert_fail = 1'b1;
    end

  // Single word bursts
  a_end_match: assert property (@(posedge ui_clk) disable iff (ui_rst)
    app_wdf_end == app_wdf_wren)
    else begin
      $error("app_wdf_end differs from app_wdf_wren");
      assert_fail = 1'b1;
    end

endmodule

bind fml_ddr3_bridge fml_ddr3_checker #(.adr_width(adr_width)) u_checker (
  .ui_clk(ui_clk), .ui_rst(ui_rst), .fml_ack(fml_ack),
  .app_en(app_en), .app_rdy(app_rdy), .app_addr(app_addr), .app_cmd(app_cmd),
  .app_wdf_wren(app_wdf_wren), .app_wdf_rdy(app_wdf_rdy),
  .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data)
);

//--- fml_ddr3_front.sv
// FML front end; one burst at a time, adr_width above 5, delays must match the FML arbiter timing
`timescale 1ns/1ns

module fml_ddr3_front #(
  parameter int adr_width = 27,
  parameter int rd_delay = 5,
  parameter int wr_delay = 2
) (
  input  logic ui_clk,
  input  logic ui_rst,
  input  logic [adr_width-1:0] fml_adr,
  input  logic fml_stb,
  input  logic fml_we,
  input  logic [7:0] fml_sel,
  input  logic [fml_ddr3_pkg::qword_bits-1:0] fml_di,
  output logic fml_ack,
  output logic [fml_ddr3_pkg::qword_bits-1:0] fml_do,
  output logic rd_start,
  output logic wr_start,
  output logic [adr_width-1:0] burst_addr,
  output fml_ddr3_pkg::app_word_u wr_word,
  output fml_ddr3_pkg::app_mask_u wr_mask,
  input  logic rd_done,
  input  logic wr_done,
  input  fml_ddr3_pkg::app_word_u rd_word
);

  localparam int dly_max = (rd_delay > wr_delay) ? rd_delay : wr_delay;
  localparam int dly_bits = $clog2(dly_max + 2);

  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_wr_collect = 3'd1;
  localparam logic [2:0] st_wr_wait    = 3'd2;
  localparam logic [2:0] st_rd_wait    = 3'd3;
  localparam logic [2:0] st_rd_emit    = 3'd4;

  logic [2:0] state;
  logic [dly_bits-1:0] dly;
  logic [1:0] beat;
  logic [1:0] offset;
  logic [7:0] sel_n;
  logic beat_tick;
  logic last_beat;

  // Delay spent, one beat moves per cycle from here on
  assign beat_tick = (dly == '0);
  assign last_beat = (beat == 2'(fml_ddr3_pkg::beats - 1));

  // --------------------------------------------------
  // FML state machine
  // --------------------------------------------------
  always_ff @(posedge ui_clk) begin
    if (ui_rst) begin
      state <= st_idle;
      fml_ack <= 1'b0;
      fml_do <= '0;
      rd_start <= 1'b0;
      wr_start <= 1'b0;
      dly <= '0;
      beat <= '0;
      offset <= '0;
    end else begin
      fml_ack <= 1'b0;
      rd_start <= 1'b0;
      wr_start <= 1'b0;
      case (state)
        st_idle: begin
          if (fml_stb) begin
            // Critical word first, start at the addressed beat
            offset <= fml_adr[4:3];
            beat <= '0;
            if (fml_we) begin
              fml_ack <= 1'b1;
              dly <= dly_bits'(wr_delay);
              state <= st_wr_collect;
            end else begin
              rd_start <= 1'b1;
              state <= st_rd_wait;
            end
          end
        end
        st_wr_collect: begin
          if (!beat_tick) begin
            dly <= dly - 1'b1;
          end else begin
            offset <= offset + 2'd1;
            beat <= beat + 2'd1;
            if (last_beat) begin
              wr_start <= 1'b1;
              state <= st_wr_wait;
            end
          end
        end
        st_wr_wait: begin
          if (wr_done) begin
            state <= st_idle;
          end
        end
        st_rd_wait: begin
          // Ack only once the controller word is in hand
          if (rd_done) begin
            fml_ack <= 1'b1;
            dly <= dly_bits'(rd_delay);
            state <= st_rd_emit;
          end
        end
        st_rd_emit: begin
          if (!beat_tick) begin
            dly <= dly - 1'b1;
          end else begin
            fml_do <= rd_word.qword[offset];
            offset <= offset + 2'd1;
            beat <= beat + 2'd1;
            if (last_beat) begin
              state <= st_idle;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // Write buffer and mask build
  // --------------------------------------------------
  always_ff @(posedge ui_clk) begin
    if (state == st_idle && fml_stb) begin
      // Burst is 32 bytes, so the low 5 address bits drop
      burst_addr <= {fml_adr[adr_width-1:5], 5'b0};
      sel_n <= ~fml_sel;
    end
    if (state == st_wr_collect && beat_tick) begin
      wr_word.qword[offset] <= fml_di;
      wr_mask.qbyte[offset] <= sel_n;
    end
  end

endmodule

//--- fml_ddr3_pkg.sv
// Shared bridge constants; sized for a 64-bit FML port and a 256-bit BC4 controller port only
package fml_ddr3_pkg;

  // --------------------------------------------------
  // Controller command codes
  // --------------------------------------------------
  localparam logic [2:0] cmd_write = 3'b000;
  localparam logic [2:0] cmd_read  = 3'b001;

  // --------------------------------------------------
  // Burst geometry
  // --------------------------------------------------
  // FML beats per burst
  localparam int beats = 4;
  localparam int qword_bits = 64;

  // Controller side word and byte mask
  localparam int app_data_bits = 256;
  localparam int app_mask_bits = 32;

  // --------------------------------------------------
  // Data word views
  // --------------------------------------------------
  // Beat i sits in bits 64i+63 down to 64i
  typedef union packed {
    logic [app_data_bits-1:0] flat;
    logic [beats-1:0][qword_bits-1:0] qword;
  } app_word_u;

  // Mask bit set means the byte is left untouched
  typedef union packed {
    logic [app_mask_bits-1:0] flat;
    logic [beats-1:0][app_mask_bits/beats-1:0] qbyte;
  } app_mask_u;

endpackage

//--- fml_ddr3_rd_ctl.sv
// Read side; one command outstanding, expects a single word flagged by valid and end together
`timescale 1ns/1ns

module fml_ddr3_rd_ctl #(
  parameter int adr_width = 27
) (
  input  logic ui_clk,
  input  logic ui_rst,
  input  logic rd_start,
  input  logic [adr_width-1:0] burst_addr,
  app_cmd_if.ctl cmd,
  input  logic [fml_ddr3_pkg::app_data_bits-1:0] app_rd_data,
  input  logic app_rd_data_valid,
  input  logic app_rd_data_end,
  output logic rd_done,
  output fml_ddr3_pkg::app_word_u rd_word
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_cmd  = 2'd1;
  localparam logic [1:0] st_data = 2'd2;

  logic [1:0] state;
  logic data_hit;

  assign data_hit = app_rd_data_valid & app_rd_data_end;

  always_ff @(posedge ui_clk) begin
    if (ui_rst) begin
      state <= st_idle;
      cmd.en <= 1'b0;
      rd_done <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      case (state)
        st_idle: begin
          if (rd_start) begin
            cmd.en <= 1'b1;
            state <= st_cmd;
          end
        end
        st_cmd: begin
          // Request leaves the port on the accepting edge
          if (cmd.rdy) begin
            cmd.en <= 1'b0;
            state <= st_data;
          end
        end
        st_data: begin
          if (data_hit) begin
            rd_done <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Command fields and returned word
  always_ff @(posedge ui_clk) begin
    if (state == st_idle && rd_start) begin
      cmd.addr <= burst_addr;
      cmd.cmd <= fml_ddr3_pkg::cmd_read;
    end
    if (state == st_data && data_hit) begin
      rd_word.flat <= app_rd_data;
    end
  end

endmodule

//--- fml_ddr3_wr_ctl.sv
// Write side; one command then one 256-bit data word, held until the controller takes it
`timescale 1ns/1ns

module fml_ddr3_wr_ctl #(
  parameter int adr_width = 27
) (
  input  logic ui_clk,
  input  logic ui_rst,
  input  logic wr_start,
  input  logic [adr_width-1:0] burst_addr,
  input  fml_ddr3_pkg::app_word_u wr_word,
  input  fml_ddr3_pkg::app_mask_u wr_mask,
  app_cmd_if.ctl cmd,
  input  logic app_wdf_rdy,
  output logic [fml_ddr3_pkg::app_data_bits-1:0] app_wdf_data,
  output logic [fml_ddr3_pkg::app_mask_bits-1:0] app_wdf_mask,
  output logic app_wdf_wren,
  output logic app_wdf_end,
  output logic wr_done
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_cmd  = 2'd1;
  localparam logic [1:0] st_data = 2'd2;

  logic [1:0] state;
  logic cmd_taken;

  assign cmd_taken = cmd.en & cmd.rdy;

  // Single word bursts, so every beat is also the last
  assign app_wdf_end = app_wdf_wren;

  // --------------------------------------------------
  // Command then data sequencing
  // --------------------------------------------------
  always_ff @(posedge ui_clk) begin
    if (ui_rst) begin
      state <= st_idle;
      cmd.en <= 1'b0;
      app_wdf_wren <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      wr_done <= 1'b0;
      case (state)
        st_idle: begin
          if (wr_start) begin
            cmd.en <= 1'b1;
            state <= st_cmd;
          end
        end
        st_cmd: begin
          if (cmd_taken) begin
            cmd.en <= 1'b0;
            app_wdf_wren <= 1'b1;
            state <= st_data;
          end
        end
        st_data: begin
          if (app_wdf_rdy) begin
            app_wdf_wren <= 1'b0;
            wr_done <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Fields and data word
  always_ff @(posedge ui_clk) begin
    if (state == st_idle && wr_start) begin
      cmd.addr <= burst_addr;
      cmd.cmd <= fml_ddr3_pkg::cmd_write;
    end
    if (state == st_cmd && cmd_taken) begin
      app_wdf_data <= wr_word.flat;
      app_wdf_mask <= wr_mask.flat;
    end
  end

endmodule

//--- tb_ddr3_app_model.sv
// Controller model; 64 words indexed by addr bits 10 to 5, one read in flight, stalls from rand_bits
`timescale 1ns/1ns

module tb_ddr3_app_model #(
  parameter int adr_width = 27
) (
  input  logic ui_clk,
  input  logic ui_rst,
  input  logic stall_en,
  input  logic [3:0] rand_bits,
  input  logic [adr_width-1:0] app_addr,
  input  logic [2:0] app_cmd,
  input  logic app_en,
  output logic app_rdy,
  output logic [fml_ddr3_pkg::app_data_bits-1:0] app_rd_data,
  output logic app_rd_data_valid,
  output logic app_rd_data_end,
  output logic app_wdf_rdy,
  input  logic [fml_ddr3_pkg::app_data_bits-1:0] app_wdf_data,
  input  logic [fml_ddr3_pkg::app_mask_bits-1:0] app_wdf_mask,
  input  logic app_wdf_wren,
  input  logic app_wdf_end
);

  fml_ddr3_pkg::app_word_u mem [0:63];
  logic [adr_width-1:0] log_addr [0:63];
  logic [2:0] log_cmd [0:63];
  int log_count;
  logic [5:0] rd_idx;
  logic [5:0] wr_idx;
  logic [2:0] rd_wait;
  logic rd_pend;
  logic [fml_ddr3_pkg::app_data_bits-1:0] merged;

  // Bits 0 and 1 stall the ports, bits 3 and 2 pick the read latency
  assign app_rdy = !(stall_en && rand_bits[0]);
  assign app_wdf_rdy = !(stall_en && rand_bits[1]);

  // Fill depends on word index and beat
  initial begin
    for (int i = 0; i < 64; i++) begin
      for (int q = 0; q < 4; q++) begin
        mem[i].qword[q] = {16'h5aa5, 10'(i), 6'(q), 32'(i * 4 + q)};
      end
    end
  end

  // Mask bit set keeps the old byte
  always_comb begin
    merged = mem[wr_idx];
    for (int b = 0; b < fml_ddr3_pkg::app_mask_bits; b++) begin
      if (!app_wdf_mask[b]) begin
        merged[8*b +: 8] = app_wdf_data[8*b +: 8];
      end
    end
  end

  always @(posedge ui_clk) begin
    app_rd_data_valid <= 1'b0;
    app_rd_data_end <= 1'b0;
    if (ui_rst) begin
      rd_pend <= 1'b0;
      log_count <= 0;
    end else begin
      if (app_en && app_rdy) begin
        log_addr[log_count % 64] <= app_addr;
        log_cmd[log_count % 64] <= app_cmd;
        log_count <= log_count + 1;
        if (app_cmd == fml_ddr3_pkg::cmd_read) begin
          rd_idx <= app_addr[10:5];
          rd_wait <= 3'd3 + 3'(rand_bits[3:2]);
          rd_pend <= 1'b1;
        end else begin
          wr_idx <= app_addr[10:5];
        end
      end
      if (rd_pend) begin
        if (rd_wait == 3'd1) begin
          app_rd_data <= mem[rd_idx];
          app_rd_data_valid <= 1'b1;
          app_rd_data_end <= 1'b1;
          rd_pend <= 1'b0;
        end else begin
          rd_wait <= rd_wait - 3'd1;
        end
      end
      // Only a word flagged as the last one is committed
      if (app_wdf_wren && app_wdf_end && app_wdf_rdy) begin
        mem[wr_idx] <= merged;
      end
    end
  end

endmodule

//--- tb_fml_ddr3_bridge.sv
// Bridge testbench; default parameters, stops at the first error, shadow covers written words only
`timescale 1ns/1ns

module tb_fml_ddr3_bridge;

  localparam int adr_width = 27;
  localparam int rd_delay = 5;
  localparam int wr_delay = 2;
  localparam int clk_period = 100;
  localparam int num_ops = 28;
  localparam int op_cycles = 60;
  localparam int watchdog_ns = (num_ops * op_cycles + 10) * clk_period;

  logic ui_clk;
  logic ui_rst;
  logic [adr_width-1:0] fml_adr;
  logic fml_stb;
  logic fml_we;
  logic [7:0] fml_sel;
  logic [63:0] fml_di;
  logic fml_ack;
  logic [63:0] fml_do;
  logic app_rdy;
  logic [255:0] app_rd_data;
  logic app_rd_data_valid;
  logic app_rd_data_end;
  logic app_wdf_rdy;
  logic [adr_width-1:0] app_addr;
  logic [2:0] app_cmd;
  logic app_en;
  logic [255:0] app_wdf_data;
  logic [31:0] app_wdf_mask;
  logic app_wdf_wren;
  logic app_wdf_end;
  logic stall_en;
  logic [3:0] rand_bits;
  logic [15:0] stim_lfsr = 16'd62619;
  logic [15:0] stall_lfsr = 16'd62619;
  int errors = 0;
  fml_ddr3_pkg::app_word_u shadow [0:63];

  fml_ddr3_bridge #(
    .adr_width(adr_width), .rd_delay(rd_delay), .wr_delay(wr_delay)
  ) UUT (.*);

  tb_ddr3_app_model #(.adr_width(adr_width)) u_app_model (.*);

  initial begin
    ui_clk = 1'b0;
    forever #(clk_period / 2) ui_clk = ~ui_clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) return (s >> 1) ^ 16'hb400;
    return s >> 1;
  endfunction

  // One step per bit taken
  function automatic logic [31:0] stim_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], stim_lfsr[0]};
      stim_lfsr = lfsr_step(stim_lfsr);
    end
    return v;
  endfunction

  function automatic logic [63:0] rand_qword();
    logic [31:0] hi;
    hi = stim_bits(32);
    return {hi, stim_bits(32)};
  endfunction

  // Beat k lands at word position (adr[4:3] + k) mod 4 for selected bytes only
  function automatic void expect_write(input logic [adr_width-1:0] adr, input logic [7:0] sel,
                                       input logic [3:0][63:0] data);
    logic [1:0] pos;
    for (int k = 0; k < 4; k++) begin
      pos = 2'(adr[4:3] + k);
      for (int b = 0; b < 8; b++) begin
        if (sel[b]) shadow[adr[10:5]].qword[pos][8*b +: 8] = data[k][8*b +: 8];
      end
    end
  endfunction

  function automatic logic [63:0] expect_beat(input logic [adr_width-1:0] adr, input int k);
    return shadow[adr[10:5]].qword[2'(adr[4:3] + k)];
  endfunction

  always @(posedge ui_clk) begin : stall_gen
    logic [3:0] b;
    for (int i = 0; i < 4; i++) begin
      b[i] = stall_lfsr[0];
      stall_lfsr = lfsr_step(stall_lfsr);
    end
    rand_bits <= b;
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string test_name, input logic [255:0] expected,
                             input logic [255:0] actual);
    if (expected !== actual) begin
      errors++;
      stop_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                         test_name, expected, actual));
    end
  endtask

  initial begin : watchdog
    #(watchdog_ns);
    stop_run("Watchdog timeout, an FML transaction never completed");
  end

  always @(posedge UUT.u_checker.assert_fail) begin
    stop_run("A bus protocol assertion failed in the bound checker");
  end

  // --------------------------------------------------
  // FML master with beat timing counted from the ack edge
  // --------------------------------------------------
  task automatic fml_write(input logic [adr_width-1:0] adr, input logic [7:0] sel,
                           input logic [3:0][63:0] data);
    fml_adr <= adr;
    fml_we <= 1'b1;
    fml_sel <= sel;
    fml_stb <= 1'b1;
    do @(posedge ui_clk); while (fml_ack !== 1'b1);
    fml_stb <= 1'b0;
    fml_we <= 1'b0;
    repeat (wr_delay - 1) @(posedge ui_clk);
    for (int k = 0; k < 4; k++) begin
      fml_di <= data[k];
      @(posedge ui_clk);
    end
    expect_write(adr, sel, data);
  endtask

  task automatic fml_read(input logic [adr_width-1:0] adr, output logic [3:0][63:0] data);
    fml_adr <= adr;
    fml_we <= 1'b0;
    fml_stb <= 1'b1;
    do @(posedge ui_clk); while (fml_ack !== 1'b1);
    fml_stb <= 1'b0;
    repeat (rd_delay + 1) @(posedge ui_clk);
    for (int k = 0; k < 4; k++) begin
      data[k] = fml_do;
      @(posedge ui_clk);
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic after_reset_idle();
    check_value("reset fml_ack", 1'b0, fml_ack);
    check_value("reset app_en", 1'b0, app_en);
    check_value("reset app_wdf_wren", 1'b0, app_wdf_wren);
    check_value("reset app_wdf_end", 1'b0, app_wdf_end);
    check_value("reset fml_do", 64'h0, fml_do);
  endtask

  task automatic aligned_write_read();
    logic [adr_width-1:0] adr;
    logic [3:0][63:0] wdata;
    logic [3:0][63:0] rdata;
    int n0;
    adr = 27'h0000140;
    n0 = u_app_model.log_count;
    for (int k = 0; k < 4; k++) wdata[k] = rand_qword();
    fml_write(adr, 8'hff, wdata);
    fml_read(adr, rdata);
    for (int k = 0; k < 4; k++) check_value("aligned data", wdata[k], rdata[k]);
    check_value("aligned log count", n0 + 2, u_app_model.log_count);
    check_value("aligned write cmd", fml_ddr3_pkg::cmd_write, u_app_model.log_cmd[n0 % 64]);
    check_value("aligned write addr", 27'h0000140, u_app_model.log_addr[n0 % 64]);
    check_value("aligned read cmd", fml_ddr3_pkg::cmd_read, u_app_model.log_cmd[(n0 + 1) % 64]);
    check_value("aligned read addr", 27'h0000140, u_app_model.log_addr[(n0 + 1) % 64]);
  endtask

  task automatic wrap_order();
    logic [3:0][63:0] wdata;
    logic [3:0][63:0] rdata;
    for (int k = 0; k < 4; k++) wdata[k] = rand_qword();
    // Offset 2 write fills positions 2 3 0 1
    fml_write(27'h0000290, 8'hff, wdata);
    fml_read(27'h0000280, rdata);
    for (int k = 0; k < 4; k++) check_value("wrap write", wdata[(k + 2) % 4], rdata[k]);
    fml_read(27'h0000298, rdata);
    for (int k = 0; k < 4; k++) begin
      check_value("wrap read", expect_beat(27'h0000298, k), rdata[k]);
    end
  endtask

  task automatic byte_enable_merge();
    logic [3:0][63:0] wdata;
    logic [3:0][63:0] rdata;
    for (int k = 0; k < 4; k++) wdata[k] = rand_qword();
    fml_write(27'h0000428, 8'hff, wdata);
    for (int k = 0; k < 4; k++) wdata[k] = rand_qword();
    fml_write(27'h0000438, 8'ha5, wdata);
    fml_read(27'h0000420, rdata);
    for (int k = 0; k < 4; k++) begin
      check_value("byte enables", expect_beat(27'h0000420, k), rdata[k]);
    end
  endtask

  task automatic back_pressure_pairs();
    logic [adr_width-1:0] adr;
    logic [adr_width-1:0] radr;
    logic [3:0][63:0] wdata;
    logic [3:0][63:0] rdata;
    stall_en <= 1'b1;
    for (int n = 0; n < 10; n++) begin
      adr = '0;
      adr[adr_width-1:3] = 24'(stim_bits(24));
      radr = {adr[adr_width-1:5], 2'(stim_bits(2)), 3'b0};
      for (int k = 0; k < 4; k++) wdata[k] = rand_qword();
      fml_write(adr, 8'hff, wdata);
      fml_read(radr, rdata);
      for (int k = 0; k < 4; k++) begin
        check_value("back pressure", expect_beat(radr, k), rdata[k]);
      end
    end
    stall_en <= 1'b0;
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    ui_rst = 1'b1;
    fml_adr = '0;
    fml_stb = 1'b0;
    fml_we = 1'b0;
    fml_sel = '0;
    fml_di = '0;
    stall_en = 1'b0;
    rand_bits = '0;
    repeat (2) @(posedge ui_clk);
    ui_rst <= 1'b0;
    @(posedge ui_clk);
    after_reset_idle();
    aligned_write_read();
    wrap_order();
    byte_enable_merge();
    back_pressure_pairs();
    repeat (4) @(posedge ui_clk);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
fml_ddr3_pkg.sv
app_cmd_if.sv
fml_ddr3_front.sv
fml_ddr3_rd_ctl.sv
fml_ddr3_wr_ctl.sv
fml_ddr3_app_mux.sv
fml_ddr3_bridge.sv
fml_ddr3_checker.sv
tb_ddr3_app_model.sv
tb_fml_ddr3_bridge.sv
